// File: harness_config.svh
/*
 * Harness constants. HARNESS_PD_COUNT must equal CPU + peripheral + banks + external.
 * Address windows must not overlap and the scratch window holds exactly RAM_WORDS words.
 */
`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

`define HARNESS_DATA_W 32
`define HARNESS_ADDR_W 32

// Power domains
`define HARNESS_NUM_BANKS 2
`define HARNESS_EXT_DOMAINS 1
`define HARNESS_PD_COUNT (2 + `HARNESS_NUM_BANKS + `HARNESS_EXT_DOMAINS)
`define HARNESS_SWITCH_ACK_LATENCY 15

`define HARNESS_SLOW_RAM_WORDS 64
`define HARNESS_SLOW_RAM_LATENCY 3

// Address map
`define HARNESS_CNT_BASE 32'h0000_0000
`define HARNESS_CNT_SIZE 32'h0000_0010
`define HARNESS_RAM_BASE 32'h0000_1000
`define HARNESS_RAM_SIZE (`HARNESS_SLOW_RAM_WORDS * 4)

`define HARNESS_CNT_MAX_RESET 32'd2048
`define HARNESS_NEXT_INT 4

`endif

// File: harness_pkg.sv
/*
 * Shared types of the harness. Power-domain bits are active low,
 * bit 0 CPU, bit 1 peripheral, then banks, then external domains.
 */
`default_nettype none

`include "harness_config.svh"

package harness_pkg;

  typedef logic [`HARNESS_DATA_W-1:0] data_t;
  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;

  typedef logic [`HARNESS_PD_COUNT-1:0] pd_vec_t;

  // Edge count and threshold
  typedef logic [31:0] cnt_t;

  typedef logic [$clog2(`HARNESS_SLOW_RAM_WORDS)-1:0] ram_idx_t;
  typedef logic [`HARNESS_NEXT_INT-1:0] intr_vec_t;

  // Counter register offsets, STATUS bit 0 is write-1-to-clear
  typedef enum logic [3:0] {
    CTRL      = 4'h0,
    THRESHOLD = 4'h4,
    COUNT     = 4'h8,
    STATUS    = 4'hC
  } cnt_reg_e;

endpackage

`default_nettype wire

// File: reg_bus_if.sv
/*
 * Word-only register bus. Valid and the request fields are held until ready.
 * Rdata and error are meaningful only while ready is high.
 */
`default_nettype none

interface reg_bus_if;
  import harness_pkg::*;

  logic  valid;
  logic  write;
  addr_t addr;
  data_t wdata;
  data_t rdata;
  logic  ready;
  logic  error;

  modport manager(
    output valid, write, addr, wdata,
    input  rdata, ready, error
  );

  modport subordinate(
    input  valid, write, addr, wdata,
    output rdata, ready, error
  );

endinterface

`default_nettype wire

// File: power_switch_emulator.sv
/*
 * Stand-in for the power-switch cells. Each request bit comes back as its
 * acknowledge a fixed number of rising edges later. All acks read 1 after reset.
 */
`default_nettype none

`include "harness_config.svh"

module power_switch_emulator (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  harness_pkg::pd_vec_t  switch_n_i,
  output harness_pkg::pd_vec_t  switch_ack_n_o
);
  import harness_pkg::*;

  localparam int unsigned LATENCY = `HARNESS_SWITCH_ACK_LATENCY;

  pd_vec_t ack_pipe [LATENCY];

  // Shift register, one stage per cycle of switch latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < LATENCY; i++) begin
        ack_pipe[i] <= '1;
      end
    end else begin
      ack_pipe[0] <= switch_n_i;
      for (int i = 1; i < LATENCY; i++) begin
        ack_pipe[i] <= ack_pipe[i-1];
      end
    end
  end

  assign switch_ack_n_o = ack_pipe[LATENCY-1];

  // Once the chain is fully refilled, ack mirrors the request from LATENCY cycles ago
  assert property (@(posedge clk_i) disable iff (rst_i)
    (!rst_i) [* LATENCY + 1] |-> (switch_ack_n_o == $past(switch_n_i, LATENCY)))
    else $error("switch ack does not match delayed request");

endmodule

`default_nettype wire

// File: periph_reg_demux.sv
/*
 * Routes the register bus to the counter or scratch-memory window, passing the
 * window-relative offset on. Holes answer at once with error and zero data.
 */
`default_nettype none

`include "harness_config.svh"

module periph_reg_demux (
  input logic            clk_i,
  input logic            rst_i,
  reg_bus_if.subordinate host,
  reg_bus_if.manager     cnt_bus,
  reg_bus_if.manager     ram_bus
);
  import harness_pkg::*;

  localparam addr_t CNT_BASE = `HARNESS_CNT_BASE;
  localparam addr_t CNT_SIZE = `HARNESS_CNT_SIZE;
  localparam addr_t RAM_BASE = `HARNESS_RAM_BASE;
  localparam addr_t RAM_SIZE = `HARNESS_RAM_SIZE;

  addr_t cnt_offset;
  addr_t ram_offset;
  logic  cnt_hit;
  logic  ram_hit;

  // Wrapping subtraction makes one unsigned compare per window
  assign cnt_offset = host.addr - CNT_BASE;
  assign ram_offset = host.addr - RAM_BASE;
  assign cnt_hit    = (cnt_offset < CNT_SIZE);
  assign ram_hit    = (ram_offset < RAM_SIZE);

  assign cnt_bus.valid = host.valid && cnt_hit;
  assign cnt_bus.write = host.write;
  assign cnt_bus.addr  = cnt_offset;
  assign cnt_bus.wdata = host.wdata;

  assign ram_bus.valid = host.valid && ram_hit;
  assign ram_bus.write = host.write;
  assign ram_bus.addr  = ram_offset;
  assign ram_bus.wdata = host.wdata;

  always_comb begin
    if (cnt_hit) begin
      host.rdata = cnt_bus.rdata;
      host.ready = cnt_bus.ready;
      host.error = cnt_bus.error;
    end else if (ram_hit) begin
      host.rdata = ram_bus.rdata;
      host.ready = ram_bus.ready;
      host.error = ram_bus.error;
    end else begin
      // Unmapped, complete immediately
      host.rdata = '0;
      host.ready = host.valid;
      host.error = host.valid;
    end
  end

  // Host address must lie in the absolute window of the selected slave, one slave at a time
  assert property (@(posedge clk_i) disable iff (rst_i)
    (cnt_bus.valid |-> (host.addr >= CNT_BASE) && (host.addr < CNT_BASE + CNT_SIZE)) and
    (ram_bus.valid |-> (host.addr >= RAM_BASE) && (host.addr < RAM_BASE + RAM_SIZE)) and
    !(cnt_bus.valid && ram_bus.valid))
    else $error("slave selected outside its address window");

endmodule

`default_nettype wire

// File: gpio_cnt_regs.sv
/*
 * Register block of the GPIO edge counter. COUNT is read-only and unknown
 * offsets complete with error. A wrap and a STATUS clear in one cycle keep pending set.
 */
`default_nettype none

`include "harness_config.svh"

module gpio_cnt_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  reg_bus_if.subordinate    bus,
  output logic              enable_o,
  output harness_pkg::cnt_t threshold_o,
  input  harness_pkg::cnt_t count_i,
  input  logic              wrap_i,
  output logic              irq_o
);
  import harness_pkg::*;

  logic       enable_q;
  cnt_t       threshold_q;
  logic       pending_q;
  logic [3:0] reg_off;
  logic       off_high;
  logic       bad_access;
  logic       wr_en;

  assign reg_off  = bus.addr[3:0];
  assign off_high = |bus.addr[$bits(addr_t)-1:4];

  always_comb begin
    bus.rdata  = '0;
    bad_access = off_high;
    case (reg_off)
      CTRL:      bus.rdata[0] = enable_q;
      THRESHOLD: bus.rdata    = threshold_q;
      COUNT: begin
        bus.rdata  = count_i;
        bad_access = off_high || bus.write;
      end
      STATUS:    bus.rdata[0] = pending_q;
      default:   bad_access   = 1'b1;
    endcase
  end

  assign bus.ready = bus.valid;
  assign bus.error = bus.valid && bad_access;
  assign wr_en     = bus.valid && bus.write && !bad_access;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q    <= 1'b0;
      threshold_q <= `HARNESS_CNT_MAX_RESET;
      pending_q   <= 1'b0;
    end else begin
      if (wr_en && reg_off == CTRL) begin
        enable_q <= bus.wdata[0];
      end
      if (wr_en && reg_off == THRESHOLD) begin
        threshold_q <= cnt_t'(bus.wdata);
      end
      // Set has priority so no wrap is lost
      if (wrap_i) begin
        pending_q <= 1'b1;
      end else if (wr_en && reg_off == STATUS && bus.wdata[0]) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign enable_o    = enable_q;
  assign threshold_o = threshold_q;
  assign irq_o       = pending_q;

endmodule

`default_nettype wire

// File: gpio_counter.sv
/*
 * Counts rising edges of an asynchronous GPIO input, three cycles after the edge.
 * On reaching the threshold the count clears, gpio_o toggles and wrap_o pulses.
 */
`default_nettype none

module gpio_counter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              gpio_i_i,
  input  logic              enable_i,
  input  harness_pkg::cnt_t threshold_i,
  output harness_pkg::cnt_t count_o,
  output logic              wrap_o,
  output logic              gpio_o
);
  import harness_pkg::*;

  logic [1:0] sync_q;
  logic       prev_q;
  logic       rise;
  cnt_t       count_q;
  cnt_t       count_inc;
  logic       wrap_q;
  logic       gpio_q;

  // Two-flop synchronizer, then edge register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], gpio_i_i};
      prev_q <= sync_q[1];
    end
  end

  assign rise      = sync_q[1] && !prev_q;
  assign count_inc = count_q + cnt_t'(1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      wrap_q  <= 1'b0;
      gpio_q  <= 1'b0;
    end else begin
      wrap_q <= 1'b0;
      if (enable_i && rise) begin
        if (count_inc == threshold_i) begin
          count_q <= '0;
          wrap_q  <= 1'b1;
          gpio_q  <= !gpio_q;
        end else begin
          count_q <= count_inc;
        end
      end
    end
  end

  assign count_o = count_q;
  assign wrap_o  = wrap_q;
  assign gpio_o  = gpio_q;

  // A nonzero threshold always stays above the count
  assert property (@(posedge clk_i) disable iff (rst_i)
    (threshold_i != '0) |-> (count_q < threshold_i))
    else $error("edge count reached the threshold");

endmodule

`default_nettype wire

// File: slow_ram.sv
/*
 * Scratch memory on the register bus, word accesses only. Ready comes a fixed
 * number of cycles after valid; misaligned addresses complete with error.
 */
`default_nettype none

`include "harness_config.svh"

module slow_ram (
  input logic            clk_i,
  input logic            rst_i,
  reg_bus_if.subordinate bus
);
  import harness_pkg::*;

  localparam int unsigned LATENCY = `HARNESS_SLOW_RAM_LATENCY;
  localparam int unsigned WORDS   = `HARNESS_SLOW_RAM_WORDS;
  localparam int unsigned WAIT_W  = $clog2(LATENCY + 1);

  data_t             mem [WORDS];
  data_t             rdata_q;
  logic [WAIT_W-1:0] wait_q;
  ram_idx_t          idx;
  logic              misaligned;
  logic              done;

  assign idx        = bus.addr[2 +: $bits(ram_idx_t)];
  assign misaligned = |bus.addr[1:0];
  assign done       = bus.valid && (wait_q == WAIT_W'(LATENCY));

  // Cycles of valid seen for the current transfer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
    end else if (done) begin
      wait_q <= '0;
    end else if (bus.valid) begin
      wait_q <= wait_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done && bus.write && !misaligned) begin
      mem[idx] <= bus.wdata;
    end
    if (bus.valid) begin
      rdata_q <= mem[idx];
    end
  end

  assign bus.ready = done;
  assign bus.error = done && misaligned;
  assign bus.rdata = rdata_q;

  // Manager must hold the request while waiting
  assert property (@(posedge clk_i) disable iff (rst_i)
    bus.valid && !bus.ready |=> bus.valid && $stable(bus.addr) && $stable(bus.write))
    else $error("request dropped or changed before ready");

endmodule

`default_nettype wire

// File: harness_top.sv
/*
 * External-device side of the harness: power-switch acks, the peripheral
 * register bus and the interrupt vector. Only interrupt bit 0 is in use.
 */
`default_nettype none

module harness_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  harness_pkg::addr_t     reg_addr_i,
  input  harness_pkg::data_t     reg_wdata_i,
  output harness_pkg::data_t     reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   reg_error_o,
  input  harness_pkg::pd_vec_t   pd_switch_n_i,
  output harness_pkg::pd_vec_t   pd_switch_ack_n_o,
  input  logic                   gpio_i,
  output logic                   gpio_o,
  output harness_pkg::intr_vec_t intr_vector_o
);
  import harness_pkg::*;

  reg_bus_if host_bus ();
  reg_bus_if cnt_bus ();
  reg_bus_if ram_bus ();

  logic cnt_enable;
  cnt_t cnt_threshold;
  cnt_t cnt_count;
  logic cnt_wrap;
  logic cnt_irq;

  assign host_bus.valid = reg_valid_i;
  assign host_bus.write = reg_write_i;
  assign host_bus.addr  = reg_addr_i;
  assign host_bus.wdata = reg_wdata_i;
  assign reg_rdata_o    = host_bus.rdata;
  assign reg_ready_o    = host_bus.ready;
  assign reg_error_o    = host_bus.error;

  power_switch_emulator u_power_switch (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .switch_n_i     (pd_switch_n_i),
    .switch_ack_n_o (pd_switch_ack_n_o)
  );

  periph_reg_demux u_demux (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .host    (host_bus),
    .cnt_bus (cnt_bus),
    .ram_bus (ram_bus)
  );

  gpio_cnt_regs u_cnt_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus         (cnt_bus),
    .enable_o    (cnt_enable),
    .threshold_o (cnt_threshold),
    .count_i     (cnt_count),
    .wrap_i      (cnt_wrap),
    .irq_o       (cnt_irq)
  );

  gpio_counter u_counter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .gpio_i_i    (gpio_i),
    .enable_i    (cnt_enable),
    .threshold_i (cnt_threshold),
    .count_o     (cnt_count),
    .wrap_o      (cnt_wrap),
    .gpio_o      (gpio_o)
  );

  slow_ram u_slow_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (ram_bus)
  );

  // Unused interrupt lines tied low
  always_comb begin
    intr_vector_o    = '0;
    intr_vector_o[0] = cnt_irq;
  end

endmodule

`default_nettype wire

// File: tb_harness.sv
/*
 * Testbench for harness_top, run from the project root. Vectors come from
 * tb_harness_vectors.txt; power acks are checked in the background until an I vector.
 */
`default_nettype none

`include "harness_config.svh"

module tb_harness;
  timeunit 1ns;
  timeprecision 1ps;
  import harness_pkg::*;

  localparam int unsigned ACK_LAT  = `HARNESS_SWITCH_ACK_LATENCY;
  localparam addr_t       RAM_BASE = `HARNESS_RAM_BASE;

  logic      clk_i = 1'b0;
  logic      rst_i;
  logic      reg_valid_i;
  logic      reg_write_i;
  addr_t     reg_addr_i;
  data_t     reg_wdata_i;
  data_t     reg_rdata_o;
  logic      reg_ready_o;
  logic      reg_error_o;
  pd_vec_t   pd_switch_n_i;
  pd_vec_t   pd_switch_ack_n_o;
  logic      gpio_i;
  logic      gpio_o;
  intr_vec_t intr_vector_o;

  byte         vec_op [$];
  logic [31:0] vec_a [$];
  logic [31:0] vec_b [$];
  logic [31:0] vec_c [$];
  // Power patterns in flight, with the cycle their ack is due
  int unsigned due_q [$];
  pd_vec_t     pat_q [$];
  int          ptest_q [$];
  data_t       ram_model [`HARNESS_SLOW_RAM_WORDS];
  int unsigned cycle = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          mismatches = 0;
  logic [31:0] lcg_state = 32'd22;

  harness_top dut (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .reg_valid_i       (reg_valid_i),
    .reg_write_i       (reg_write_i),
    .reg_addr_i        (reg_addr_i),
    .reg_wdata_i       (reg_wdata_i),
    .reg_rdata_o       (reg_rdata_o),
    .reg_ready_o       (reg_ready_o),
    .reg_error_o       (reg_error_o),
    .pd_switch_n_i     (pd_switch_n_i),
    .pd_switch_ack_n_o (pd_switch_ack_n_o),
    .gpio_i            (gpio_i),
    .gpio_o            (gpio_o),
    .intr_vector_o     (intr_vector_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned vector_budget(input byte op, input logic [31:0] a);
    case (op)
      "G":     return a * 8 + 8;
      "P":     return 2;
      "I":     return ACK_LAT + 8;
      default: return `HARNESS_SLOW_RAM_LATENCY + 8;
    endcase
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what,
                            output logic ok);
    ok = (got === exp);
    if (!ok) begin
      mismatches++;
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pd(input pd_vec_t got, input pd_vec_t exp, input string what,
                          output logic ok);
    ok = (got === exp);
    if (!ok) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_intr(input intr_vec_t got, input intr_vec_t exp, output logic ok);
    ok = (got === exp);
    if (!ok) begin
      mismatches++;
      $display("MISMATCH at %0t: interrupt vector is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what,
                            output logic ok);
    ok = (got === exp);
    if (!ok) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report(input int num, input string what, input logic ok);
    tests_run++;
    if (!ok) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", num, what, ok ? "ok" : "FAILED");
  endtask

  task automatic watchdog(input int unsigned cycles);
    #(cycles * 4);
    $display("Timeout: the vectors did not finish within %0d cycles", cycles);
    $display("Simulation failed");
    $finish;
  endtask

  // Blank lines and lines starting with # are skipped
  task automatic load_vectors(output logic ok);
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    ok = 1'b0;
    fd = $fopen("tb_harness_vectors.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      a = '0;
      b = '0;
      c = '0;
      n = $sscanf(line, "%c %h %h %h", op, a, b, c);
      if (n >= 1 && op != "#" && op != " " && op != "\n") begin
        vec_op.push_back(op);
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_c.push_back(c);
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  // Holds the request until the cycle in which ready is seen
  task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    do begin
      @(negedge clk_i);
    end while (!reg_ready_o);
    rdata = reg_rdata_o;
    err   = reg_error_o;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
  endtask

  task automatic run_vector(input int num, input byte op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] c);
    data_t    rdata;
    data_t    wdata;
    logic     err;
    logic     ok_a;
    logic     ok_b;
    logic     ok_c;
    logic     ok_d;
    ram_idx_t idx;
    idx = ram_idx_t'((a - RAM_BASE) >> 2);
    case (op)
      "W": begin
        bus_access(1'b1, a, b, rdata, err);
        check_flag(err, c[0], "write error", ok_a);
        report(num, $sformatf("write %h to %h", b, a), ok_a);
      end
      "R": begin
        bus_access(1'b0, a, '0, rdata, err);
        check_data(rdata, b, $sformatf("address %h", a), ok_a);
        check_flag(err, c[0], "read error", ok_b);
        report(num, $sformatf("read %h", a), ok_a && ok_b);
      end
      "L": begin
        wdata = lcg_next();
        bus_access(1'b1, a, wdata, rdata, err);
        ram_model[idx] = wdata;
        check_flag(err, 1'b0, "scratch write error", ok_a);
        report(num, $sformatf("scratch write %h to %h", wdata, a), ok_a);
      end
      "C": begin
        bus_access(1'b0, a, '0, rdata, err);
        check_data(rdata, ram_model[idx], $sformatf("scratch %h", a), ok_a);
        check_flag(err, 1'b0, "scratch read error", ok_b);
        report(num, $sformatf("scratch read %h", a), ok_a && ok_b);
      end
      "G": begin
        for (int i = 0; i < int'(a); i++) begin
          @(posedge clk_i);
          gpio_i <= 1'b1;
          repeat (4) @(posedge clk_i);
          gpio_i <= 1'b0;
          repeat (3) @(posedge clk_i);
        end
        report(num, $sformatf("%0d gpio pulses", a), 1'b1);
      end
      "P": begin
        // Captured at the next edge, then ACK_LAT stages to the output
        @(posedge clk_i);
        pd_switch_n_i <= pd_vec_t'(a);
        due_q.push_back(cycle + ACK_LAT + 1);
        pat_q.push_back(pd_vec_t'(a));
        ptest_q.push_back(num);
      end
      "I": begin
        while (due_q.size() != 0) begin
          @(negedge clk_i);
        end
        @(negedge clk_i);
        check_pd(pd_switch_ack_n_o, pd_vec_t'(a), "switch ack", ok_a);
        check_intr(intr_vector_o, intr_vec_t'(b), ok_b);
        check_flag(gpio_o, c[0], "gpio_o", ok_c);
        check_flag(reg_ready_o, 1'b0, "idle bus ready", ok_d);
        report(num, "idle outputs", ok_a && ok_b && ok_c && ok_d);
      end
      default: begin
        $display("Vector %0d has an unknown operation '%c'", num, op);
        report(num, "unknown operation", 1'b0);
      end
    endcase
  endtask

  always @(negedge clk_i) begin : ack_monitor
    logic ok;
    if (due_q.size() != 0 && cycle == due_q[0]) begin
      check_pd(pd_switch_ack_n_o, pat_q[0], "switch ack", ok);
      report(ptest_q[0], $sformatf("power pattern %b", pat_q[0]), ok);
      void'(due_q.pop_front());
      void'(pat_q.pop_front());
      void'(ptest_q.pop_front());
    end
  end

  initial begin : main
    logic        loaded;
    int unsigned budget;
    rst_i         = 1'b1;
    reg_valid_i   = 1'b0;
    reg_write_i   = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    pd_switch_n_i = '1;
    gpio_i        = 1'b0;
    load_vectors(loaded);
    if (!loaded) begin
      $display("Could not open the vector file tb_harness_vectors.txt");
      tests_failed++;
    end
    budget = 24;
    foreach (vec_op[i]) begin
      budget += vector_budget(vec_op[i], vec_a[i]);
    end
    fork
      watchdog(budget);
    join_none
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    foreach (vec_op[i]) begin
      run_vector(i + 1, vec_op[i], vec_a[i], vec_b[i], vec_c[i]);
    end
    if (due_q.size() != 0) begin
      $display("Power acks still pending when the vectors ended");
      tests_failed++;
    end
    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
             mismatches);
    if (tests_failed == 0 && mismatches == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_harness_vectors.txt
# op a b c, hex: W addr data err | R addr data err | L addr (LCG word) | C addr (read back)
# G pulses | P switch pattern (one cycle) | I ack intr gpio, after acks settle
I 1f 0 0
R 00000008 00000000 0
R 00000004 00000800 0
R 00000000 00000000 0
P 1e 0 0
P 1c 0 0
P 18 0 0
P 10 0 0
P 00 0 0
P 15 0 0
P 0a 0 0
P 1f 0 0
I 1f 0 0
L 00001000 0 0
L 00001004 0 0
L 0000103c 0 0
L 000010fc 0 0
L 00001004 0 0
C 00001000 0 0
C 00001004 0 0
C 0000103c 0 0
C 000010fc 0 0
R 00002000 00000000 1
R 00000010 00000000 1
W 00000008 00000005 1
W 00000004 00000005 0
W 00000000 00000001 0
G 4 0 0
R 00000008 00000004 0
I 1f 0 0
G 1 0 0
R 00000008 00000000 0
I 1f 1 1
W 0000000c 00000001 0
I 1f 0 1

// File: verilog.f
+incdir+.
harness_pkg.sv
reg_bus_if.sv
power_switch_emulator.sv
periph_reg_demux.sv
gpio_cnt_regs.sv
gpio_counter.sv
slow_ram.sv
harness_top.sv
tb_harness.sv
